/* verilog/stripe_pkg.sv */
package stripe_pkg;

  localparam int data_width = 16; // Lane word, sign-magnitude
  localparam int lanes      = 8;
  localparam int tag_width  = 12;
  localparam int frac_bits  = 14; // Q1.14 words
  localparam int acc_width  = 32; // Sign in msb, 28 fraction bits below

  typedef enum logic [1:0] {
    op_add  = 2'd0,
    op_sub  = 2'd1,
    op_mul  = 2'd2,
    op_rsvd = 2'd3
  } op_t;

  typedef struct packed {
    op_t  op;
    logic accumulate; // Add step result into accumulator
    logic ret;        // Raise return request when done
  } instr_t;

  // Lane n sits in word n
  typedef logic [lanes-1:0][data_width-1:0] block_t;

  typedef struct packed {
    instr_t               instr;
    logic [tag_width-1:0] tag_a;
    logic [tag_width-1:0] tag_b;
    logic [tag_width-1:0] stride_a;
    logic [tag_width-1:0] stride_b;
    logic [tag_width-1:0] iter_lim;
  } stripe_cmd_t;

  // One beat of the shared bus, two tagged halves
  typedef struct packed {
    logic [tag_width-1:0] tag0;
    logic [tag_width-1:0] tag1;
    block_t               d0;
    block_t               d1;
  } bus_beat_t;

endpackage

/* verilog/stripe_sequencer.sv */
module stripe_sequencer import stripe_pkg::*; #(
  parameter int lanes      = stripe_pkg::lanes,
  parameter int data_width = stripe_pkg::data_width,
  parameter int tag_width  = stripe_pkg::tag_width
) (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             load,
  input  stripe_cmd_t                      cmd,
  input  logic                             beat_valid,
  input  bus_beat_t                        beat,
  output instr_t                           instr,
  output logic                             fire,
  output logic                             clear_acc,
  output logic [lanes-1:0][data_width-1:0] block_a,
  output logic [lanes-1:0][data_width-1:0] block_b,
  output logic                             done
);

  logic [tag_width-1:0] tag_a;    // Current A tag that advances per step
  logic [tag_width-1:0] tag_b;
  logic [tag_width-1:0] stride_a;
  logic [tag_width-1:0] stride_b;
  logic [tag_width-1:0] iter_lim;
  logic [tag_width-1:0] count;    // Steps completed
  logic [tag_width-1:0] count_inc;

  logic have_a; // Operand A captured for this step
  logic have_b;

  // Tag hits on each bus half
  logic a_on_0;
  logic a_on_1;
  logic b_on_0;
  logic b_on_1;
  logic cap_a;
  logic cap_b;

  assign a_on_0 = beat.tag0 == tag_a;
  assign a_on_1 = beat.tag1 == tag_a;
  assign b_on_0 = beat.tag0 == tag_b;
  assign b_on_1 = beat.tag1 == tag_b;

  // Beats are dropped while a step fires or a command loads
  assign cap_a = beat_valid & ~fire & ~load & (a_on_0 | a_on_1);
  assign cap_b = beat_valid & ~fire & ~load & (b_on_0 | b_on_1);

  assign fire      = have_a & have_b & ~done;
  assign clear_acc = load; // Lanes clear on the loading edge
  assign count_inc = count + 1'b1;

  always_ff @(posedge clk) begin
    if (rst) begin
      instr    <= '0;
      tag_a    <= '0;
      tag_b    <= '0;
      stride_a <= '0;
      stride_b <= '0;
      iter_lim <= '0;
      count    <= '0;
      have_a   <= 1'b0;
      have_b   <= 1'b0;
      done     <= 1'b0;
    end else if (load) begin
      instr    <= cmd.instr;
      tag_a    <= cmd.tag_a;
      tag_b    <= cmd.tag_b;
      stride_a <= cmd.stride_a;
      stride_b <= cmd.stride_b;
      iter_lim <= cmd.iter_lim;
      count    <= '0;
      have_a   <= 1'b0;
      have_b   <= 1'b0;
      // A zero limit is reached as soon as the count clears
      done     <= cmd.iter_lim == '0;
    end else if (fire) begin
      tag_a  <= tag_a + stride_a; // Wraps at tag width
      tag_b  <= tag_b + stride_b;
      count  <= count_inc;
      have_a <= 1'b0;
      have_b <= 1'b0;
      done   <= count_inc == iter_lim;
    end else begin
      if (cap_a) begin
        have_a <= 1'b1;
      end
      if (cap_b) begin
        have_b <= 1'b1;
      end
    end
  end

  // A prefers half 0 and B prefers half 1
  always_ff @(posedge clk) begin
    if (cap_a) begin
      block_a <= a_on_0 ? beat.d0 : beat.d1;
    end
    if (cap_b) begin
      block_b <= b_on_1 ? beat.d1 : beat.d0;
    end
  end

  // Completion holds until the next load
  done_holds: assert property (
    @(posedge clk) disable iff (rst) done && !load |=> done
  );

  // No step fires once the limit is reached
  fire_below_limit: assert property (
    @(posedge clk) disable iff (rst) fire |-> count < iter_lim
  );

  count_within_limit: assert property (
    @(posedge clk) disable iff (rst) count <= iter_lim
  );

endmodule

/* verilog/lane_pe.sv */
module lane_pe import stripe_pkg::*; #(
  parameter int data_width = stripe_pkg::data_width
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  fire,
  input  logic                  clear_acc,
  input  instr_t                instr,
  input  logic [data_width-1:0] a,
  input  logic [data_width-1:0] b,
  output logic [data_width-1:0] result
);

  localparam int aw = 2 * data_width; // Accumulator width
  localparam int fb = data_width - 2; // Fraction bits of a word
  localparam int mw = data_width - 1; // Word magnitude width

  // Internal sign-magnitude value, 2*fb fraction bits
  typedef struct packed {
    logic          sign;
    logic [aw-2:0] mag;
  } sm_t;

  // Sign-magnitude add, zero always positive
  function automatic sm_t sm_add(sm_t x, sm_t y);
    sm_t s;
    if (x.sign == y.sign) begin
      s.mag  = x.mag + y.mag;
      s.sign = x.sign;
    end else if (x.mag >= y.mag) begin
      s.mag  = x.mag - y.mag;
      s.sign = x.sign;
    end else begin
      s.mag  = y.mag - x.mag;
      s.sign = y.sign;
    end
    if (s.mag == '0) begin
      s.sign = 1'b0;
    end
    return s;
  endfunction

  logic [aw-2:0] mag_a; // Raw word magnitudes, zero extended
  logic [aw-2:0] mag_b;
  sm_t           op_a;
  sm_t           op_b;
  sm_t           prod;
  sm_t           step;
  sm_t           acc_d;
  sm_t           acc_q;
  logic          rnd_up;
  logic [mw-1:0] rnd_mag;

  always_comb begin
    mag_a = (aw-1)'(a[mw-1:0]);
    mag_b = (aw-1)'(b[mw-1:0]);

    // Align to the accumulator binary point
    op_a.sign = a[data_width-1];
    op_a.mag  = mag_a << fb;
    op_b.sign = b[data_width-1] ^ (instr.op == op_sub); // a - b as a + (-b)
    op_b.mag  = mag_b << fb;

    prod.mag  = mag_a * mag_b; // Q1.14 x Q1.14 lands on 28 fraction bits
    prod.sign = (a[data_width-1] ^ b[data_width-1]) & (|prod.mag);

    case (instr.op)
      op_add, op_sub: step = sm_add(op_a, op_b);
      op_mul:         step = prod;
      default:        step = '0;
    endcase

    acc_d = instr.accumulate ? sm_add(step, acc_q) : step;
  end

  always_ff @(posedge clk) begin
    if (rst || clear_acc) begin
      acc_q <= '0;
    end else if (fire) begin
      acc_q <= acc_d;
    end
  end

  // Round half to even back to Q1.14
  always_comb begin
    rnd_up  = acc_q.mag[fb-1] & ((|acc_q.mag[fb-2:0]) | acc_q.mag[fb]);
    rnd_mag = acc_q.mag[2*fb:fb] + mw'(rnd_up);
  end

  assign result = {acc_q.sign & (|rnd_mag), rnd_mag}; // No negative zero

  // Sequencer must never fire with an undefined opcode
  no_rsvd_op_fire: assert property (
    @(posedge clk) disable iff (rst) fire |-> instr.op != op_rsvd
  );

endmodule

/* verilog/tensor_stripe.sv */
module tensor_stripe import stripe_pkg::*; #(
  parameter int lanes      = stripe_pkg::lanes,
  parameter int data_width = stripe_pkg::data_width,
  parameter int tag_width  = stripe_pkg::tag_width
) (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             load,
  input  stripe_cmd_t                      cmd,
  input  logic                             beat_valid,
  input  bus_beat_t                        beat,
  output logic                             ext_req,
  output logic [lanes-1:0][data_width-1:0] d_out
);

  instr_t                           instr;
  logic                             fire;
  logic                             clear_acc;
  logic                             done;
  logic [lanes-1:0][data_width-1:0] block_a;
  logic [lanes-1:0][data_width-1:0] block_b;
  logic [lanes-1:0][data_width-1:0] result; // Rounded lane outputs

  stripe_sequencer #(
    .lanes      (lanes),
    .data_width (data_width),
    .tag_width  (tag_width)
  ) sequencer_i (
    .clk        (clk),
    .rst        (rst),
    .load       (load),
    .cmd        (cmd),
    .beat_valid (beat_valid),
    .beat       (beat),
    .instr      (instr),
    .fire       (fire),
    .clear_acc  (clear_acc),
    .block_a    (block_a),
    .block_b    (block_b),
    .done       (done)
  );

  for (genvar n = 0; n < lanes; n++) begin : g_lane
    lane_pe #(
      .data_width (data_width)
    ) lane_i (
      .clk       (clk),
      .rst       (rst),
      .fire      (fire),
      .clear_acc (clear_acc),
      .instr     (instr),
      .a         (block_a[n]),
      .b         (block_b[n]),
      .result    (result[n])
    );
  end

  assign ext_req = done & instr.ret;
  assign d_out   = ext_req ? result : '0; // Bus stays quiet unless returning

  // Return request is a level that only a new command drops
  ext_req_level: assert property (
    @(posedge clk) disable iff (rst) ext_req && !load |=> ext_req
  );

endmodule

/* verif/stripe_checker.sv */
module stripe_checker import stripe_pkg::*; #(
  parameter int timeout_cycles = 7200
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        load,
  input  stripe_cmd_t cmd,
  input  logic        beat_valid,
  input  bus_beat_t   beat,
  input  logic        ext_req,
  input  block_t      d_out,
  input  logic [3:0]  test_num,
  input  logic        test_done,
  output int          check_count,
  output int          error_count,
  output logic        timed_out
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam longint scale = longint'(1) << frac_bits; // Word to accumulator alignment

  instr_t                m_instr; // Expected sequencer state
  logic [tag_width-1:0]  m_tag_a;
  logic [tag_width-1:0]  m_tag_b;
  logic [tag_width-1:0]  m_stride_a;
  logic [tag_width-1:0]  m_stride_b;
  logic [tag_width-1:0]  m_lim;
  logic [tag_width-1:0]  m_count;
  logic                  m_have_a;
  logic                  m_have_b;
  logic                  m_done;
  logic                  m_reported; // First return cycle already compared
  block_t                m_blk_a;
  block_t                m_blk_b;
  longint                m_acc [lanes]; // Exact lane values, 28 fraction bits
  logic                  exp_req;
  logic [data_width-1:0] exp_word;
  int                    test_checks;
  int                    test_errors;
  int                    cycles;

  assign timed_out = cycles >= timeout_cycles;

  function automatic longint word_value(logic [data_width-1:0] w);
    longint m;
    m = longint'(w[data_width-2:0]);
    return w[data_width-1] ? -m : m;
  endfunction

  function automatic longint step_value(op_t op, logic [data_width-1:0] a,
                                        logic [data_width-1:0] b);
    case (op)
      op_add:  return (word_value(a) + word_value(b)) * scale;
      op_sub:  return (word_value(a) - word_value(b)) * scale;
      default: return word_value(a) * word_value(b);
    endcase
  endfunction

  // Back to Q1.14, ties go to the even value
  function automatic logic [data_width-1:0] round_word(longint acc);
    longint                mag;
    longint                q;
    longint                r;
    logic [data_width-2:0] omag;
    mag = acc < 0 ? -acc : acc;
    q   = mag / scale;
    r   = mag % scale;
    if (r > scale / 2 || (r == scale / 2 && q % 2 == 1)) begin
      q = q + 1;
    end
    omag = q[data_width-2:0]; // Output magnitude wraps
    return {acc < 0 && omag != '0, omag};
  endfunction

  function automatic string test_name(logic [3:0] n);
    case (n)
      4'd1:    return "reset and first command";
      4'd2:    return "multiply accumulate";
      4'd3:    return "add and subtract";
      4'd4:    return "swapped bus halves";
      4'd5:    return "noise beats";
      4'd6:    return "return disabled then enabled";
      default: return "unnamed";
    endcase
  endfunction

  task automatic record(input logic ok);
    test_checks++;
    check_count++;
    if (!ok) begin
      test_errors++;
      error_count++;
    end
  endtask

  task automatic restart_model();
    m_count    = '0;
    m_have_a   = 1'b0;
    m_have_b   = 1'b0;
    m_done     = 1'b0;
    m_reported = 1'b0;
    for (int n = 0; n < lanes; n++) begin
      m_acc[n] = 0;
    end
  endtask

  initial begin
    check_count = 0;
    error_count = 0;
    test_checks = 0;
    test_errors = 0;
    cycles      = 0;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles == timeout_cycles) begin
      $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
    end
    if (rst) begin
      m_instr    = '0;
      m_tag_a    = '0;
      m_tag_b    = '0;
      m_stride_a = '0;
      m_stride_b = '0;
      m_lim      = '0;
      restart_model();
    end else begin
      exp_req = m_done & m_instr.ret;
      if (ext_req !== exp_req) begin
        $display("error test %0d: ext_req expected %h got %h", test_num, exp_req, ext_req);
      end
      record(ext_req === exp_req);
      if (exp_req && !m_reported) begin
        for (int n = 0; n < lanes; n++) begin
          exp_word = round_word(m_acc[n]);
          if (d_out[n] !== exp_word) begin
            $display("error test %0d: d_out lane %0d expected %h got %h",
                     test_num, n, exp_word, d_out[n]);
          end
          record(d_out[n] === exp_word);
        end
        m_reported = 1'b1;
      end else if (!exp_req) begin
        if (d_out !== '0) begin
          $display("error test %0d: d_out expected %h got %h", test_num, block_t'(0), d_out);
        end
        record(d_out === '0);
      end

      // Advance the model by one edge
      if (load) begin
        m_instr    = cmd.instr;
        m_tag_a    = cmd.tag_a;
        m_tag_b    = cmd.tag_b;
        m_stride_a = cmd.stride_a;
        m_stride_b = cmd.stride_b;
        m_lim      = cmd.iter_lim;
        restart_model();
        m_done     = cmd.iter_lim == '0; // Count already at a zero limit
      end else if (m_have_a && m_have_b && !m_done) begin
        for (int n = 0; n < lanes; n++) begin
          m_acc[n] = (m_instr.accumulate ? m_acc[n] : 0)
                   + step_value(m_instr.op, m_blk_a[n], m_blk_b[n]);
        end
        m_count  = m_count + tag_width'(1);
        m_tag_a  = m_tag_a + m_stride_a;
        m_tag_b  = m_tag_b + m_stride_b;
        m_have_a = 1'b0;
        m_have_b = 1'b0;
        m_done   = m_count == m_lim;
      end else if (beat_valid) begin
        if (beat.tag0 == m_tag_a || beat.tag1 == m_tag_a) begin
          m_blk_a  = beat.tag0 == m_tag_a ? beat.d0 : beat.d1;
          m_have_a = 1'b1;
        end
        if (beat.tag1 == m_tag_b || beat.tag0 == m_tag_b) begin
          m_blk_b  = beat.tag1 == m_tag_b ? beat.d1 : beat.d0;
          m_have_b = 1'b1;
        end
      end
    end
    if (test_done) begin
      $display("test %0d %s: %0d checks, %0d errors",
               test_num, test_name(test_num), test_checks, test_errors);
      test_checks = 0;
      test_errors = 0;
    end
  end

endmodule

/* verif/tb_stripe.sv */
module tb_stripe import stripe_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int n_tests     = 6;
  localparam int max_steps   = 40; // Timeout budget per test
  localparam int step_cycles = 30;

  logic        clk = 1'b0;
  logic        rst;
  logic        load;
  stripe_cmd_t cmd;
  logic        beat_valid;
  bus_beat_t   beat;
  logic        ext_req;
  block_t      d_out;
  logic [3:0]  test_num;
  logic        test_done;
  int          check_count;
  int          error_count;
  logic        timed_out;
  integer      seed = 32'h6dd986dc;

  logic [tag_width-1:0] cur_a;  // Tags of the step being sent
  logic [tag_width-1:0] cur_b;
  logic [tag_width-1:0] prev_a; // Previous step tags reused as noise
  logic [tag_width-1:0] prev_b;
  logic [tag_width-1:0] stride_a;
  logic [tag_width-1:0] stride_b;

  always #4 clk = ~clk;

  tensor_stripe #(
    .lanes      (lanes),
    .data_width (data_width),
    .tag_width  (tag_width)
  ) tensor_stripe_i (
    .clk        (clk),
    .rst        (rst),
    .load       (load),
    .cmd        (cmd),
    .beat_valid (beat_valid),
    .beat       (beat),
    .ext_req    (ext_req),
    .d_out      (d_out)
  );

  stripe_checker #(
    .timeout_cycles (n_tests * max_steps * step_cycles)
  ) checker_i (
    .clk         (clk),
    .rst         (rst),
    .load        (load),
    .cmd         (cmd),
    .beat_valid  (beat_valid),
    .beat        (beat),
    .ext_req     (ext_req),
    .d_out       (d_out),
    .test_num    (test_num),
    .test_done   (test_done),
    .check_count (check_count),
    .error_count (error_count),
    .timed_out   (timed_out)
  );

  function automatic int unsigned pick(int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic logic [tag_width-1:0] any_tag();
    return tag_width'(pick(1 << tag_width));
  endfunction

  // Magnitude below 0.25 so six-step sums stay in range
  function automatic logic [data_width-1:0] small_word();
    logic [data_width-2:0] mag;
    mag = (data_width-1)'(pick(1 << (frac_bits - 2)));
    return {pick(2) == 1, mag};
  endfunction

  function automatic block_t random_block();
    block_t blk;
    for (int n = 0; n < lanes; n++) begin
      blk[n] = small_word();
    end
    return blk;
  endfunction

  // Keep the wanted tag unless the current step uses it
  function automatic logic [tag_width-1:0] noise_tag(logic [tag_width-1:0] want);
    logic [tag_width-1:0] t;
    t = want;
    while (t == cur_a || t == cur_b) begin
      t = any_tag();
    end
    return t;
  endfunction

  task automatic drive_beat(logic [tag_width-1:0] t0, logic [tag_width-1:0] t1,
                            block_t d0, block_t d1);
    @(negedge clk);
    load       = 1'b0;
    test_done  = 1'b0;
    beat_valid = 1'b1;
    beat.tag0  = t0;
    beat.tag1  = t1;
    beat.d0    = d0;
    beat.d1    = d1;
  endtask

  task automatic idle_cycle();
    @(negedge clk);
    load       = 1'b0;
    test_done  = 1'b0;
    beat_valid = 1'b0;
  endtask

  task automatic noise_cycle();
    drive_beat(noise_tag(pick(2) == 1 ? prev_a : any_tag()),
               noise_tag(pick(2) == 1 ? prev_b : any_tag()), random_block(), random_block());
  endtask

  task automatic pause(bit noise);
    repeat (pick(3)) begin
      if (noise && pick(2) == 1) begin
        noise_cycle();
      end else begin
        idle_cycle();
      end
    end
  endtask

  // Home half is 0 for A and 1 for B
  task automatic send_operand(bit is_b, bit swap, block_t data);
    logic [tag_width-1:0] tag;
    logic [tag_width-1:0] other; // Tag on the half without the operand
    tag   = is_b ? cur_b : cur_a;
    other = noise_tag(any_tag());
    if (!swap && pick(4) == 0) begin // Same tag on both halves
      other = tag;
    end
    if (is_b ^ swap) begin
      drive_beat(other, tag, random_block(), data);
    end else begin
      drive_beat(tag, other, data, random_block());
    end
  endtask

  task automatic run_step(op_t op, bit swap, bit noise, bit cancel);
    block_t a;
    block_t b;
    bit     b_first;
    a = random_block();
    b = random_block();
    for (int n = 0; n < lanes; n++) begin
      if (cancel && pick(2) == 1) begin // Result of zero
        b[n] = op == op_sub ? a[n] : {~a[n][data_width-1], a[n][data_width-2:0]};
      end
    end
    pause(noise);
    if (pick(3) == 0) begin
      if (swap) begin
        drive_beat(cur_b, cur_a, b, a);
      end else begin
        drive_beat(cur_a, cur_b, a, b);
      end
    end else begin
      b_first = pick(2) == 1;
      send_operand(b_first, swap, b_first ? b : a);
      pause(noise);
      send_operand(!b_first, swap, b_first ? a : b);
    end
    if (noise) begin // Fire cycle
      noise_cycle();
    end else begin
      idle_cycle();
    end
    prev_a = cur_a;
    prev_b = cur_b;
    cur_a  = cur_a + stride_a;
    cur_b  = cur_b + stride_b;
  endtask

  task automatic load_command(op_t op, bit accumulate, bit ret, int steps);
    bit clash;
    clash = 1'b1;
    while (clash) begin // A and B tags must differ on every step
      cur_a    = any_tag();
      cur_b    = any_tag();
      stride_a = tag_width'(1 + pick((1 << tag_width) - 1));
      stride_b = tag_width'(1 + pick((1 << tag_width) - 1));
      clash    = 1'b0;
      for (int k = 0; k <= steps; k++) begin
        if (tag_width'(cur_a + k * stride_a) == tag_width'(cur_b + k * stride_b)) begin
          clash = 1'b1;
        end
      end
    end
    prev_a = cur_a;
    prev_b = cur_b;
    @(negedge clk);
    test_done            = 1'b0;
    beat_valid           = 1'b0;
    load                 = 1'b1;
    cmd.instr.op         = op;
    cmd.instr.accumulate = accumulate;
    cmd.instr.ret        = ret;
    cmd.tag_a            = cur_a;
    cmd.tag_b            = cur_b;
    cmd.stride_a         = stride_a;
    cmd.stride_b         = stride_b;
    cmd.iter_lim         = tag_width'(steps);
  endtask

  // Swap mode 0 keeps halves, 1 swaps, 2 picks per step
  task automatic run_command(op_t op, bit accumulate, bit ret, int steps, int swap_mode,
                             bit noise, bit cancel);
    load_command(op, accumulate, ret, steps);
    for (int s = 0; s < steps; s++) begin
      run_step(op, swap_mode == 2 ? pick(2) == 1 : swap_mode == 1, noise, cancel);
    end
    if (ret) begin
      while (ext_req !== 1'b1) begin
        idle_cycle();
      end
      idle_cycle(); // Checker samples the first return cycle
    end else begin
      repeat (4) begin
        idle_cycle();
      end
    end
  endtask

  task automatic start_test(int n);
    idle_cycle();
    test_num = 4'(n);
  endtask

  task automatic end_test();
    @(negedge clk);
    load       = 1'b0;
    beat_valid = 1'b0;
    test_done  = 1'b1;
  endtask

  always @(negedge clk) begin
    if (timed_out) begin
      $display("ERRORS FOUND");
      $finish;
    end
  end

  initial begin
    rst        = 1'b1;
    load       = 1'b0;
    cmd        = '0;
    beat_valid = 1'b0;
    beat       = '0;
    test_num   = 4'd0;
    test_done  = 1'b0;
    cur_a      = '0;
    cur_b      = '0;
    prev_a     = '0;
    prev_b     = '0;
    stride_a   = '0;
    stride_b   = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    start_test(1); // Stray beats before any command
    repeat (12) begin
      if (pick(2) == 1) begin
        noise_cycle();
      end else begin
        idle_cycle();
      end
    end
    run_command(op_mul, 1'b1, 1'b1, 2, 0, 1'b0, 1'b0);
    end_test();

    start_test(2);
    run_command(op_mul, 1'b1, 1'b1, 1 + pick(6), 0, 1'b0, 1'b0);
    run_command(op_mul, 1'b1, 1'b1, 1 + pick(6), 0, 1'b0, 1'b0);
    end_test();

    start_test(3);
    run_command(op_add, 1'b0, 1'b1, 2 + pick(5), 0, 1'b0, 1'b1);
    run_command(op_sub, 1'b0, 1'b1, 2 + pick(5), 0, 1'b0, 1'b1);
    end_test();

    start_test(4);
    run_command(op_mul, 1'b1, 1'b1, 1 + pick(6), 1, 1'b0, 1'b0);
    run_command(op_sub, 1'b0, 1'b1, 1 + pick(6), 2, 1'b0, 1'b0);
    end_test();

    start_test(5);
    run_command(op_mul, 1'b1, 1'b1, 1 + pick(6), 2, 1'b1, 1'b0);
    run_command(op_add, 1'b0, 1'b1, 1 + pick(6), 0, 1'b1, 1'b0);
    end_test();

    start_test(6); // Second load must start from cleared accumulators
    run_command(op_mul, 1'b1, 1'b0, 1 + pick(6), 0, 1'b0, 1'b0);
    run_command(op_mul, 1'b1, 1'b1, 1 + pick(6), 0, 1'b0, 1'b0);
    end_test();

    idle_cycle();
    $display("summary: %0d tests, %0d checks, %0d errors", n_tests, check_count, error_count);
    if (error_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* verilog.f */
verilog/stripe_pkg.sv
verilog/stripe_sequencer.sv
verilog/lane_pe.sv
verilog/tensor_stripe.sv
verif/stripe_checker.sv
verif/tb_stripe.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run, then look for the fail message in the log
verilator --binary --timing --assert -Wno-fatal --top-module tb_stripe -f verilog.f \
  -Mdir obj_dir -o sim_stripe > build.log 2>&1 \
  && ./obj_dir/sim_stripe > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "simulation did not complete"; exit 1; }
cat sim.log
grep -q "ERRORS FOUND" sim.log && exit 1 || exit 0
